//--- Makefile
# Verilator build and run for the UART testbench

VERILATOR ?= verilator
TOP       ?= uart_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ns

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
	  echo "run FAILED, see $(LOG)"; exit 1; \
	elif ! grep -q "Simulation passed" $(LOG); then \
	  echo "run did not complete, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
common/uart_timing_pkg.sv
common/uart_types_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_top.sv
sim/serial_line_model.sv
sim/uart_assertions.sv
sim/uart_tb.sv

//--- common/uart_timing_pkg.sv
package uart_timing_pkg;

  // --------------------------------------------------
  // serial line timing, all counts in clk cycles
  // --------------------------------------------------

  // length of one serial bit
  localparam int unsigned bit_cycles = 8;

  // receiver samples each bit here, counted from the bit's start
  localparam int unsigned half_bit_cycles = bit_cycles / 2;

  // 8N1: start, eight data bits, stop
  localparam int unsigned frame_bits = 10;

  // flops on the asynchronous rx input
  localparam int unsigned sync_stages = 2;

endpackage

//--- common/uart_types_pkg.sv
package uart_types_pkg;

  // --------------------------------------------------
  // data and counter types
  // --------------------------------------------------

  typedef logic [7:0] uart_byte_t;

  // index of the current bit inside one frame
  typedef logic [3:0] bit_count_t;

  // clk cycles elapsed inside one bit
  typedef logic [3:0] cycle_count_t;

  // --------------------------------------------------
  // state machines
  // --------------------------------------------------

  typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} tx_state_t;

  typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;

endpackage

//--- design/uart_rx.sv
`timescale 1ns/1ns

module uart_rx (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       rx,
  output uart_types_pkg::uart_byte_t data,
  output logic                       valid,
  output logic                       frame_error
);

  import uart_timing_pkg::*;
  import uart_types_pkg::*;

  localparam cycle_count_t last_cycle = cycle_count_t'(bit_cycles - 1);
  localparam cycle_count_t mid_start  = cycle_count_t'(half_bit_cycles - 1);
  localparam bit_count_t   last_bit   = bit_count_t'($bits(uart_byte_t) - 1);

  logic [sync_stages-1:0] sync_q;
  logic                   rx_s;
  logic                   rx_prev;
  logic                   fall;

  rx_state_t    state;
  cycle_count_t cycle_cnt;
  bit_count_t   bit_cnt;
  uart_byte_t   shift_q;

  logic sample_tick;
  logic stop_tick;

  // --------------------------------------------------
  // input synchronizer and edge detect
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      // line idles high
      sync_q  <= '1;
      rx_prev <= 1'b1;
    end else begin
      sync_q  <= {sync_q[sync_stages-2:0], rx};
      rx_prev <= rx_s;
    end
  end

  assign rx_s = sync_q[sync_stages-1];
  assign fall = rx_prev && !rx_s;

  // data and stop bits are sampled once per bit, mid-bit
  assign sample_tick = (state == rx_data) && (cycle_cnt == last_cycle);
  assign stop_tick   = (state == rx_stop) && (cycle_cnt == last_cycle);

  // --------------------------------------------------
  // receive FSM
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= rx_idle;
      cycle_cnt   <= '0;
      bit_cnt     <= '0;
      valid       <= 1'b0;
      frame_error <= 1'b0;
    end else begin
      valid       <= 1'b0;
      frame_error <= 1'b0;
      cycle_cnt   <= cycle_cnt + 1'b1;
      case (state)
        rx_idle: begin
          cycle_cnt <= '0;
          if (fall) begin
            state <= rx_start;
          end
        end
        rx_start: begin
          if (cycle_cnt == mid_start) begin
            cycle_cnt <= '0;
            bit_cnt   <= '0;
            // high again at mid-bit means it was a glitch
            state     <= rx_s ? rx_idle : rx_data;
          end
        end
        rx_data: begin
          if (sample_tick) begin
            cycle_cnt <= '0;
            bit_cnt   <= bit_cnt + 1'b1;
            if (bit_cnt == last_bit) begin
              state <= rx_stop;
            end
          end
        end
        rx_stop: begin
          if (stop_tick) begin
            valid       <= rx_s;
            frame_error <= !rx_s;
            state       <= rx_idle;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  // --------------------------------------------------
  // data path
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (sample_tick) begin
      // LSB arrives first, shift in from the top
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

  // output byte only changes on a good frame
  always_ff @(posedge clk) begin
    if (stop_tick && rx_s) begin
      data <= shift_q;
    end
  end

endmodule

//--- design/uart_top.sv
`timescale 1ns/1ns

module uart_top (
  input  logic                       clk,
  input  logic                       rst,

  // parallel transmit side
  input  uart_types_pkg::uart_byte_t tx_data,
  input  logic                       tx_valid,
  output logic                       tx_busy,

  // parallel receive side
  output uart_types_pkg::uart_byte_t rx_data,
  output logic                       rx_valid,
  output logic                       rx_frame_error,

  // serial pins
  input  logic                       rx,
  output logic                       tx
);

  // --------------------------------------------------
  // transmit direction
  // --------------------------------------------------
  uart_tx u_tx (
    .clk   (clk),
    .rst   (rst),
    .data  (tx_data),
    .valid (tx_valid),
    .busy  (tx_busy),
    .tx    (tx)
  );

  // --------------------------------------------------
  // receive direction, rx is asynchronous here
  // --------------------------------------------------
  uart_rx u_rx (
    .clk         (clk),
    .rst         (rst),
    .rx          (rx),
    .data        (rx_data),
    .valid       (rx_valid),
    .frame_error (rx_frame_error)
  );

endmodule

//--- design/uart_tx.sv
`timescale 1ns/1ns

module uart_tx (
  input  logic                     clk,
  input  logic                     rst,
  input  uart_types_pkg::uart_byte_t data,
  input  logic                     valid,
  output logic                     busy,
  output logic                     tx
);

  import uart_timing_pkg::*;
  import uart_types_pkg::*;

  localparam cycle_count_t last_cycle = cycle_count_t'(bit_cycles - 1);
  // frame index of the last data bit, the stop bit follows it
  localparam bit_count_t last_data_bit = bit_count_t'(frame_bits - 2);

  tx_state_t    state;
  cycle_count_t cycle_cnt;
  bit_count_t   bit_cnt;
  uart_byte_t   shift_q;

  logic accept;
  logic bit_end;

  // strobes during a frame are simply dropped
  assign accept  = (state == tx_idle) && valid;
  assign bit_end = (cycle_cnt == last_cycle);
  assign busy    = (state != tx_idle);

  // --------------------------------------------------
  // frame sequencing
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= tx_idle;
      cycle_cnt <= '0;
      bit_cnt   <= '0;
      tx        <= 1'b1;
    end else begin
      cycle_cnt <= bit_end ? '0 : cycle_cnt + 1'b1;
      case (state)
        tx_idle: begin
          cycle_cnt <= '0;
          if (accept) begin
            bit_cnt <= '0;
            tx      <= 1'b0;
            state   <= tx_start;
          end
        end
        tx_start: begin
          if (bit_end) begin
            bit_cnt <= bit_cnt + 1'b1;
            tx      <= shift_q[0];
            state   <= tx_data;
          end
        end
        tx_data: begin
          if (bit_end) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == last_data_bit) begin
              tx    <= 1'b1;
              state <= tx_stop;
            end else begin
              // next bit, before the shift below moves it to bit 0
              tx <= shift_q[1];
            end
          end
        end
        tx_stop: begin
          if (bit_end) begin
            state <= tx_idle;
          end
        end
        default: state <= tx_idle;
      endcase
    end
  end

  // --------------------------------------------------
  // data shift register, LSB goes out first
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (accept) begin
      shift_q <= data;
    end else if (state == tx_data && bit_end) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

endmodule

//--- sim/serial_line_model.sv
`timescale 1ns/1ns

module serial_line_model (
  input  logic clk,
  input  logic line_from_dut,
  output logic line_to_dut
);

  import uart_timing_pkg::*;
  import uart_types_pkg::*;

  localparam int drive_delay = 5;

  // idle line is high
  initial begin
    line_to_dut = 1'b1;
  end

  // --------------------------------------------------
  // far side transmitter, drives the DUT's rx pin
  // --------------------------------------------------
  task automatic send_frame(input uart_byte_t b, input logic bad_stop);
    logic [frame_bits-1:0] bits;
    bits = {~bad_stop, b, 1'b0};
    for (int i = 0; i < frame_bits; i++) begin
      @(posedge clk);
      #drive_delay;
      line_to_dut = bits[i];
      repeat (bit_cycles - 1) @(posedge clk);
    end
    // back to idle, also after a low stop bit
    @(posedge clk);
    #drive_delay;
    line_to_dut = 1'b1;
  endtask

  // --------------------------------------------------
  // far side receiver, decodes the DUT's tx pin
  // --------------------------------------------------
  task automatic receive_frame(input int timeout_cycles, output logic found,
                               output uart_byte_t b, output logic stop_bit);
    int waited;
    uart_byte_t shift;
    found = 1'b0;
    stop_bit = 1'b0;
    shift = '0;
    waited = 0;
    while (!found && waited < timeout_cycles) begin
      @(negedge clk);
      waited++;
      found = !line_from_dut;
    end
    if (found) begin
      // move to the middle of the start bit
      repeat (half_bit_cycles) @(negedge clk);
      for (int i = 0; i < 8; i++) begin
        repeat (bit_cycles) @(negedge clk);
        shift[i] = line_from_dut;
      end
      repeat (bit_cycles) @(negedge clk);
      stop_bit = line_from_dut;
    end
    b = shift;
  endtask

endmodule

//--- sim/uart_assertions.sv
`timescale 1ns/1ns

module uart_assertions (
  input logic clk,
  input logic rst,
  input logic tx_valid,
  input logic tx_busy,
  input logic tx,
  input logic rx_valid,
  input logic rx_frame_error
);

  // set by the first transmit strobe after reset
  logic valid_seen;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_seen <= 1'b0;
    end else if (tx_valid) begin
      valid_seen <= 1'b1;
    end
  end

  // --------------------------------------------------
  // port rules
  // --------------------------------------------------
  tx_idle_high: assert property (@(posedge clk) disable iff (rst) !tx_busy |-> tx)
    else $error("tx low while tx_busy is low");

  rx_one_result: assert property (@(posedge clk) disable iff (rst)
    !(rx_valid && rx_frame_error))
    else $error("rx_valid and rx_frame_error high together");

  busy_after_strobe: assert property (@(posedge clk) disable iff (rst)
    !valid_seen |-> !tx_busy)
    else $error("tx_busy high before any tx_valid");

endmodule

bind uart_top uart_assertions u_checks (
  .clk            (clk),
  .rst            (rst),
  .tx_valid       (tx_valid),
  .tx_busy        (tx_busy),
  .tx             (tx),
  .rx_valid       (rx_valid),
  .rx_frame_error (rx_frame_error)
);

//--- sim/uart_tb.sv
`timescale 1ns/1ns

module uart_tb;

  import uart_timing_pkg::*;
  import uart_types_pkg::*;

  localparam int frame_cycles = frame_bits * bit_cycles;
  // pin edge to strobe, plus one bit of margin
  localparam int rx_latency_max = sync_stages + half_bit_cycles + 10 * bit_cycles + 1;
  localparam int num_duplex = 16;

  logic       clk;
  logic       rst;
  uart_byte_t tx_data;
  logic       tx_valid;
  logic       tx_busy;
  uart_byte_t rx_data;
  logic       rx_valid;
  logic       rx_frame_error;
  logic       rx;
  logic       tx;

  int errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int valid_count = 0;
  int frame_err_count = 0;
  int seed = 32'hf42c_6bd1;
  uart_byte_t rx_seen_q[$];

  uart_top uut (
    .clk            (clk),
    .rst            (rst),
    .tx_data        (tx_data),
    .tx_valid       (tx_valid),
    .tx_busy        (tx_busy),
    .rx_data        (rx_data),
    .rx_valid       (rx_valid),
    .rx_frame_error (rx_frame_error),
    .rx             (rx),
    .tx             (tx)
  );

  serial_line_model line (
    .clk           (clk),
    .line_from_dut (tx),
    .line_to_dut   (rx)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // receive strobes, sampled mid-cycle
  always @(negedge clk) begin
    if (!rst && rx_valid) begin
      valid_count++;
      rx_seen_q.push_back(rx_data);
    end
    if (!rst && rx_frame_error) begin
      frame_err_count++;
    end
  end

  // --------------------------------------------------
  // compare and report helpers
  // --------------------------------------------------
  task automatic check_byte(input string name, input uart_byte_t expected,
                            input uart_byte_t actual);
    if (expected !== actual) begin
      $display("Error: %s expected 0x%02h, got 0x%02h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (expected !== actual) begin
      $display("Error: %s expected 0x%0h, got 0x%0h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("Error: %s expected 0x%0h, got 0x%0h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what, input int limit);
    $display("Timeout: %s did not happen within %0d cycles", what, limit);
    errors++;
  endtask

  task automatic finish_test(input string name, input int start_errors);
    if (errors == start_errors) begin
      $display("test %s: ok", name);
      tests_passed++;
    end else begin
      $display("test %s: %0d errors", name, errors - start_errors);
      tests_failed++;
    end
  endtask

  // --------------------------------------------------
  // stimulus helpers
  // --------------------------------------------------
  task automatic strobe_tx(input uart_byte_t b);
    @(posedge clk);
    #5;
    tx_data  = b;
    tx_valid = 1'b1;
    @(posedge clk);
    #5;
    tx_valid = 1'b0;
  endtask

  task automatic wait_tx_idle(input int limit);
    int waited;
    logic busy;
    waited = 0;
    busy = 1'b1;
    while (busy && waited < limit) begin
      @(negedge clk);
      waited++;
      busy = tx_busy;
    end
    if (busy) begin
      report_timeout("tx_busy falling", limit);
    end
  endtask

  task automatic wait_rx_result(input int limit, output logic seen);
    int cycles;
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < limit) begin
      @(negedge clk);
      cycles++;
      seen = rx_valid || rx_frame_error;
    end
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------
  task automatic test_reset_idle();
    int start_errors;
    int v0;
    int e0;
    start_errors = errors;
    v0 = valid_count;
    e0 = frame_err_count;
    @(negedge clk);
    check_bit("tx", 1'b1, tx);
    check_bit("tx_busy", 1'b0, tx_busy);
    repeat (2 * frame_cycles) @(posedge clk);
    check_count("rx_valid pulses", 0, valid_count - v0);
    check_count("rx_frame_error pulses", 0, frame_err_count - e0);
    finish_test("reset_idle", start_errors);
  endtask

  task automatic test_transmit();
    int start_errors;
    int cycles;
    logic busy;
    logic found;
    logic stop_bit;
    uart_byte_t got;
    start_errors = errors;
    cycles = 0;
    busy = 1'b1;
    fork
      line.receive_frame(frame_cycles, found, got, stop_bit);
      begin
        strobe_tx(8'hb4);
        // cycle 1 is the first one after the strobe edge
        while (busy && cycles < 2 * frame_cycles) begin
          @(negedge clk);
          cycles++;
          busy = tx_busy;
        end
      end
    join
    if (busy) begin
      report_timeout("tx_busy falling", 2 * frame_cycles);
    end else begin
      check_count("tx_busy fall cycle", frame_cycles + 1, cycles);
    end
    if (!found) begin
      report_timeout("start bit on tx", frame_cycles);
    end else begin
      check_byte("tx byte", 8'hb4, got);
      check_bit("tx stop bit", 1'b1, stop_bit);
    end
    finish_test("transmit", start_errors);
  endtask

  // sends one frame on rx and checks the single resulting strobe
  task automatic receive_one(input uart_byte_t b, input logic bad_stop);
    int v0;
    int e0;
    logic seen;
    v0 = valid_count;
    e0 = frame_err_count;
    fork
      line.send_frame(b, bad_stop);
      wait_rx_result(rx_latency_max, seen);
    join
    repeat (bit_cycles) @(posedge clk);
    if (!seen) begin
      report_timeout("receive strobe", rx_latency_max);
    end
    check_count("rx_valid pulses", bad_stop ? 0 : 1, valid_count - v0);
    check_count("rx_frame_error pulses", bad_stop ? 1 : 0, frame_err_count - e0);
  endtask

  task automatic test_receive();
    int start_errors;
    start_errors = errors;
    receive_one(8'h3c, 1'b0);
    check_byte("rx_data", 8'h3c, rx_data);
    finish_test("receive", start_errors);
  endtask

  task automatic test_framing_error();
    int start_errors;
    start_errors = errors;
    // a good frame first, so the held byte is known
    receive_one(8'h5a, 1'b0);
    receive_one(8'hc7, 1'b1);
    check_byte("rx_data held", 8'h5a, rx_data);
    repeat (bit_cycles) @(posedge clk);
    receive_one(8'h81, 1'b0);
    check_byte("rx_data", 8'h81, rx_data);
    finish_test("framing_error", start_errors);
  endtask

  task automatic test_strobe_while_busy();
    int start_errors;
    logic found;
    logic stop_bit;
    uart_byte_t got;
    start_errors = errors;
    fork
      line.receive_frame(frame_cycles, found, got, stop_bit);
      begin
        strobe_tx(8'h69);
        repeat (3 * bit_cycles) @(posedge clk);
        @(negedge clk);
        check_bit("tx_busy", 1'b1, tx_busy);
        strobe_tx(8'h96);
      end
    join
    if (!found) begin
      report_timeout("start bit on tx", frame_cycles);
    end else begin
      check_byte("tx byte", 8'h69, got);
      check_bit("tx stop bit", 1'b1, stop_bit);
    end
    line.receive_frame(frame_cycles, found, got, stop_bit);
    check_bit("extra start edge on tx", 1'b0, found);
    finish_test("strobe_while_busy", start_errors);
  endtask

  task automatic test_full_duplex();
    int start_errors;
    int waited;
    logic found;
    logic stop_bit;
    uart_byte_t got;
    uart_byte_t out_bytes[num_duplex];
    uart_byte_t in_bytes[num_duplex];
    uart_byte_t model_q[$];
    start_errors = errors;
    for (int i = 0; i < num_duplex; i++) begin
      out_bytes[i] = uart_byte_t'($random(seed));
      in_bytes[i]  = uart_byte_t'($random(seed));
    end
    rx_seen_q.delete();
    fork
      for (int i = 0; i < num_duplex; i++) begin
        wait_tx_idle(2 * frame_cycles);
        strobe_tx(out_bytes[i]);
      end
      for (int i = 0; i < num_duplex; i++) begin
        line.receive_frame(2 * frame_cycles, found, got, stop_bit);
        if (found) begin
          model_q.push_back(got);
          check_bit("tx stop bit", 1'b1, stop_bit);
        end
      end
      for (int i = 0; i < num_duplex; i++) begin
        line.send_frame(in_bytes[i], 1'b0);
      end
    join
    waited = 0;
    while (rx_seen_q.size() < num_duplex && waited < rx_latency_max) begin
      @(posedge clk);
      waited++;
    end
    check_count("bytes decoded from tx", num_duplex, model_q.size());
    check_count("rx_valid bytes", num_duplex, rx_seen_q.size());
    for (int i = 0; i < num_duplex; i++) begin
      if (i < model_q.size()) begin
        check_byte("tx byte", out_bytes[i], model_q[i]);
      end
      if (i < rx_seen_q.size()) begin
        check_byte("rx_data", in_bytes[i], rx_seen_q[i]);
      end
    end
    finish_test("full_duplex", start_errors);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    rst      = 1'b1;
    tx_data  = '0;
    tx_valid = 1'b0;
    repeat (10) @(posedge clk);
    #5;
    rst = 1'b0;
    test_reset_idle();
    test_transmit();
    test_receive();
    test_framing_error();
    test_strobe_while_busy();
    test_full_duplex();
    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (errors == 0 && tests_failed == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
